// File: vlog.f
+incdir+hdl
+incdir+testbench
hdl/eth_rx_pkg.sv
hdl/eth_rx_stream_if.sv
hdl/mii_rx_decode.sv
hdl/rx_fcs_check.sv
hdl/rx_frame_fifo.sv
hdl/eth_mac_mii_rx.sv
testbench/tb_eth_mac_mii_rx.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_eth_mac_mii_rx
FILELIST  ?= vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir

// File: testbench/tb_frame_table.svh
`ifndef TB_FRAME_TABLE_SVH
`define TB_FRAME_TABLE_SVH

// Expected outcome of one frame
localparam logic [2:0] OUT_GOOD      = 3'd0;
localparam logic [2:0] OUT_BAD_FCS   = 3'd1;
localparam logic [2:0] OUT_BAD_FRAME = 3'd2;
localparam logic [2:0] OUT_OVERFLOW  = 3'd3;
localparam logic [2:0] OUT_NONE      = 3'd4;

// er_nib counts nibbles from the first preamble nibble, 0 means no rx_er
typedef struct packed {
    int unsigned len;
    bit          corrupt;
    int unsigned er_nib;
    bit          no_sfd;
    int unsigned gap;
    logic [2:0]  outcome;
} frame_row_t;

localparam int N_ROWS = 9;

// Columns: payload length, corrupt FCS, rx_er nibble, drop SFD, gap cycles, outcome
localparam frame_row_t FRAME_TABLE [N_ROWS] = '{
    '{60, 1'b0,  0, 1'b0, 200, OUT_GOOD},
    '{64, 1'b0,  0, 1'b0, 300, OUT_GOOD},
    '{60, 1'b1,  0, 1'b0, 100, OUT_BAD_FCS},
    '{60, 1'b0, 50, 1'b0, 100, OUT_BAD_FRAME},
    '{40, 1'b0,  0, 1'b0, 100, OUT_BAD_FRAME},
    '{60, 1'b0,  0, 1'b1, 100, OUT_NONE},
    '{90, 1'b0,  0, 1'b0, 300, OUT_OVERFLOW},
    '{60, 1'b0,  0, 1'b0, 200, OUT_GOOD},
    '{62, 1'b0,  0, 1'b0, 200, OUT_GOOD}
};

`endif

// File: testbench/tb_eth_mac_mii_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eth_mac_mii_rx;

    `include "tb_frame_table.svh"

    logic       logic_clk;
    logic       logic_rst;
    logic [3:0] mii_rxd;
    logic       mii_rx_dv;
    logic       mii_rx_er;
    logic [7:0] rx_axis_tdata;
    logic       rx_axis_tvalid;
    logic       rx_axis_tready;
    logic       rx_axis_tlast;
    logic       rx_error_bad_frame;
    logic       rx_error_bad_fcs;
    logic       rx_fifo_overflow;
    logic       rx_fifo_bad_frame;
    logic       rx_fifo_good_frame;

    // Expected output bytes of good frames in arrival order
    logic [7:0] exp_data [$];
    logic       exp_last [$];

    int cnt_good;
    int cnt_fifo_bad;
    int cnt_overflow;
    int cnt_err_frame;
    int cnt_err_fcs;
    int cycles;
    int cycle_limit;
    int good_rows;
    logic hold_ready_low;

    eth_mac_mii_rx DUT (
        .logic_clk          (logic_clk),
        .logic_rst          (logic_rst),
        .mii_rxd            (mii_rxd),
        .mii_rx_dv          (mii_rx_dv),
        .mii_rx_er          (mii_rx_er),
        .rx_axis_tdata      (rx_axis_tdata),
        .rx_axis_tvalid     (rx_axis_tvalid),
        .rx_axis_tready     (rx_axis_tready),
        .rx_axis_tlast      (rx_axis_tlast),
        .rx_error_bad_frame (rx_error_bad_frame),
        .rx_error_bad_fcs   (rx_error_bad_fcs),
        .rx_fifo_overflow   (rx_fifo_overflow),
        .rx_fifo_bad_frame  (rx_fifo_bad_frame),
        .rx_fifo_good_frame (rx_fifo_good_frame)
    );

    initial begin
        logic_clk = 1'b0;
        forever begin
            #20 logic_clk = ~logic_clk;
        end
    end

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // Ethernet CRC-32 computed bitwise with the LSB first
    function automatic logic [31:0] frame_crc(input logic [7:0] bytes [$]);
        logic [31:0] crc;
        logic fb;
        crc = 32'hFFFF_FFFF;
        foreach (bytes[k]) begin
            for (int b = 0; b < 8; b++) begin
                fb = crc[0] ^ bytes[k][b];
                crc = {1'b0, crc[31:1]};
                if (fb) begin
                    crc = crc ^ 32'hEDB8_8320;
                end
            end
        end
        return ~crc;
    endfunction

    task automatic send_frame(input frame_row_t row);
        logic [7:0] payload [$];
        logic [7:0] wire_bytes [$];
        logic [31:0] fcs;
        int nib;
        for (int i = 0; i < row.len; i++) begin
            payload.push_back(8'($urandom));
        end
        fcs = frame_crc(payload);
        if (row.corrupt) begin
            fcs = fcs ^ 32'h0000_0001;
        end
        for (int i = 0; i < 7; i++) begin
            wire_bytes.push_back(8'h55);
        end
        // Anything other than preamble or SFD makes the decoder drop the frame
        wire_bytes.push_back(row.no_sfd ? 8'h0F : 8'hD5);
        foreach (payload[i]) begin
            wire_bytes.push_back(payload[i]);
        end
        for (int i = 0; i < 4; i++) begin
            wire_bytes.push_back(fcs[8*i +: 8]);
        end
        if (row.outcome == OUT_GOOD) begin
            foreach (payload[i]) begin
                exp_data.push_back(payload[i]);
                exp_last.push_back(i == payload.size() - 1);
            end
        end
        hold_ready_low <= (row.outcome == OUT_OVERFLOW);
        nib = 0;
        foreach (wire_bytes[i]) begin
            for (int h = 0; h < 2; h++) begin
                @(posedge logic_clk);
                mii_rxd   <= h ? wire_bytes[i][7:4] : wire_bytes[i][3:0];
                mii_rx_dv <= 1'b1;
                mii_rx_er <= (row.er_nib != 0) && (nib == row.er_nib);
                nib++;
            end
        end
        @(posedge logic_clk);
        mii_rx_dv <= 1'b0;
        mii_rx_er <= 1'b0;
        mii_rxd   <= 4'h0;
        // Let the pulses arrive before the output drains again
        repeat (20) @(posedge logic_clk);
        hold_ready_low <= 1'b0;
        repeat (row.gap) @(posedge logic_clk);
    endtask

    task automatic run_row(input frame_row_t row);
        int good0;
        int fbad0;
        int ovf0;
        int efr0;
        int efcs0;
        good0 = cnt_good;
        fbad0 = cnt_fifo_bad;
        ovf0  = cnt_overflow;
        efr0  = cnt_err_frame;
        efcs0 = cnt_err_fcs;
        send_frame(row);
        compare("rx_fifo_good_frame", cnt_good - good0, (row.outcome == OUT_GOOD));
        compare("rx_fifo_bad_frame", cnt_fifo_bad - fbad0,
                (row.outcome == OUT_BAD_FCS) || (row.outcome == OUT_BAD_FRAME));
        compare("rx_fifo_overflow", cnt_overflow - ovf0, (row.outcome == OUT_OVERFLOW));
        compare("rx_error_bad_frame", cnt_err_frame - efr0,
                (row.outcome == OUT_BAD_FRAME));
        compare("rx_error_bad_fcs", cnt_err_fcs - efcs0, (row.outcome == OUT_BAD_FCS));
    endtask

    // Ready back-pressure that stays low while an overflow frame arrives
    always @(posedge logic_clk) begin
        if (logic_rst || hold_ready_low) begin
            rx_axis_tready <= 1'b0;
        end else begin
            rx_axis_tready <= ($urandom % 4) != 0;
        end
    end

    // Output monitor and pulse counters
    always @(posedge logic_clk) begin
        if (!logic_rst) begin
            cnt_good      += rx_fifo_good_frame;
            cnt_fifo_bad  += rx_fifo_bad_frame;
            cnt_overflow  += rx_fifo_overflow;
            cnt_err_frame += rx_error_bad_frame;
            cnt_err_fcs   += rx_error_bad_fcs;
            if (rx_axis_tvalid && rx_axis_tready) begin
                if (exp_data.size() == 0) begin
                    $display("output byte %0h arrived with no frame expected", rx_axis_tdata);
                    $display("ERRORS FOUND");
                    $fatal(1);
                end
                compare("rx_axis_tdata", rx_axis_tdata, exp_data.pop_front());
                compare("rx_axis_tlast", rx_axis_tlast, exp_last.pop_front());
            end
        end
    end

    always @(posedge logic_clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the test did not finish", cycles);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    initial begin
        void'($urandom(32'ha266_6685));
        cnt_good = 0;
        cnt_fifo_bad = 0;
        cnt_overflow = 0;
        cnt_err_frame = 0;
        cnt_err_fcs = 0;
        cycles = 0;
        good_rows = 0;
        hold_ready_low = 1'b0;
        logic_rst = 1'b1;
        mii_rxd = 4'h0;
        mii_rx_dv = 1'b0;
        mii_rx_er = 1'b0;
        rx_axis_tready = 1'b0;
        cycle_limit = 500;
        foreach (FRAME_TABLE[r]) begin
            // Twice the nibble count of a row plus its idle gap
            cycle_limit += 2 * (2 * (8 + FRAME_TABLE[r].len + 4)) + FRAME_TABLE[r].gap;
            good_rows += (FRAME_TABLE[r].outcome == OUT_GOOD);
        end
        repeat (10) @(posedge logic_clk);
        logic_rst <= 1'b0;
        repeat (5) @(posedge logic_clk);
        foreach (FRAME_TABLE[r]) begin
            run_row(FRAME_TABLE[r]);
        end
        while (exp_data.size() != 0) begin
            @(posedge logic_clk);
        end
        repeat (5) @(posedge logic_clk);
        compare("rx_fifo_good_frame total", cnt_good, good_rows);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/eth_mac_mii_rx.sv
`timescale 1ns/1ps
`default_nettype none

module eth_mac_mii_rx (
    input  wire                  logic_clk,
    input  wire                  logic_rst,

    // MII receive
    input  eth_rx_pkg::nibble_t  mii_rxd,
    input  wire                  mii_rx_dv,
    input  wire                  mii_rx_er,

    // Received frames
    output eth_rx_pkg::byte_t    rx_axis_tdata,
    output logic                 rx_axis_tvalid,
    input  wire                  rx_axis_tready,
    output logic                 rx_axis_tlast,

    // Status pulses
    output logic                 rx_error_bad_frame,
    output logic                 rx_error_bad_fcs,
    output logic                 rx_fifo_overflow,
    output logic                 rx_fifo_bad_frame,
    output logic                 rx_fifo_good_frame
);

    // Decoder to FCS check
    eth_rx_stream_if dec_stream ();
    // FCS check to frame FIFO
    eth_rx_stream_if fcs_stream ();

    mii_rx_decode u_decode (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .mii_rxd   (mii_rxd),
        .mii_rx_dv (mii_rx_dv),
        .mii_rx_er (mii_rx_er),
        .out       (dec_stream.source)
    );

    rx_fcs_check u_fcs_check (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .in        (dec_stream.sink),
        .out       (fcs_stream.source),
        .bad_frame (rx_error_bad_frame),
        .bad_fcs   (rx_error_bad_fcs)
    );

    rx_frame_fifo u_frame_fifo (
        .logic_clk      (logic_clk),
        .logic_rst      (logic_rst),
        .in             (fcs_stream.sink),
        .rx_axis_tdata  (rx_axis_tdata),
        .rx_axis_tvalid (rx_axis_tvalid),
        .rx_axis_tready (rx_axis_tready),
        .rx_axis_tlast  (rx_axis_tlast),
        .good_frame     (rx_fifo_good_frame),
        .bad_frame      (rx_fifo_bad_frame),
        .overflow       (rx_fifo_overflow)
    );

endmodule

`default_nettype wire

// File: hdl/rx_frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_defs.svh"

module rx_frame_fifo (
    input  wire                  logic_clk,
    input  wire                  logic_rst,
    eth_rx_stream_if.sink        in,
    output eth_rx_pkg::byte_t    rx_axis_tdata,
    output logic                 rx_axis_tvalid,
    input  wire                  rx_axis_tready,
    output logic                 rx_axis_tlast,
    output logic                 good_frame,
    output logic                 bad_frame,
    output logic                 overflow
);

    localparam int AW = `ETH_RX_FIFO_ADDR_WIDTH;
    localparam int DEPTH = 1 << AW;

    // Each entry is {last, data}
    logic [8:0] mem [DEPTH];

    eth_rx_pkg::fifo_ptr_t wr_ptr;
    eth_rx_pkg::fifo_ptr_t commit_ptr;
    eth_rx_pkg::fifo_ptr_t rd_ptr;
    logic drop_q;
    logic full;
    logic wr_en;
    logic rd_en;

    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_en = in.valid && !drop_q && !full;

    // Only committed frames are read out
    assign rd_en = (!rx_axis_tvalid || rx_axis_tready) && (rd_ptr != commit_ptr);

    // Write side
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            drop_q     <= 1'b0;
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
            if (in.valid) begin
                if (drop_q || full) begin
                    // Out of room so the rest is discarded and the frame rewound at its end
                    if (in.last) begin
                        drop_q   <= 1'b0;
                        wr_ptr   <= commit_ptr;
                        overflow <= 1'b1;
                    end else begin
                        drop_q <= 1'b1;
                    end
                end else if (in.last) begin
                    if (in.user) begin
                        wr_ptr    <= commit_ptr;
                        bad_frame <= 1'b1;
                    end else begin
                        wr_ptr     <= wr_ptr + 1'b1;
                        commit_ptr <= wr_ptr + 1'b1;
                        good_frame <= 1'b1;
                    end
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= {in.last, in.data};
        end
    end

    // Read side with one output register
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr         <= '0;
            rx_axis_tvalid <= 1'b0;
        end else if (rd_en) begin
            rd_ptr         <= rd_ptr + 1'b1;
            rx_axis_tvalid <= 1'b1;
        end else if (rx_axis_tready) begin
            rx_axis_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (rd_en) begin
            {rx_axis_tlast, rx_axis_tdata} <= mem[rd_ptr[AW-1:0]];
        end
    end

    // Read pointer never passes the committed pointer
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (AW+1)'(commit_ptr - rd_ptr) <= (AW+1)'(wr_ptr - rd_ptr));

endmodule

`default_nettype wire

// File: hdl/rx_fcs_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_defs.svh"

module rx_fcs_check (
    input  wire               logic_clk,
    input  wire               logic_rst,
    eth_rx_stream_if.sink     in,
    eth_rx_stream_if.source   out,
    output logic              bad_frame,
    output logic              bad_fcs
);

    // Reflected CRC-32 as used by Ethernet
    localparam eth_rx_pkg::crc_t CRC_POLY = 32'hEDB8_8320;
    localparam eth_rx_pkg::crc_t CRC_INIT = 32'hFFFF_FFFF;
    // Register value after running over payload and a correct FCS
    localparam eth_rx_pkg::crc_t CRC_MAGIC = 32'hDEBB_20E3;

    localparam int LEN_W = $clog2(`ETH_RX_MIN_FRAME_LEN + 1);
    localparam logic [LEN_W-1:0] MIN_LEN = LEN_W'(`ETH_RX_MIN_FRAME_LEN);
    localparam logic [LEN_W-1:0] SR_DEPTH = LEN_W'(4);

    eth_rx_pkg::crc_t crc_q;
    eth_rx_pkg::crc_t crc_nxt;
    eth_rx_pkg::byte_t delay_sr [4];
    logic [LEN_W-1:0] byte_cnt;
    logic sr_full;
    logic too_short;
    logic frame_bad;
    logic fcs_ok;

    function automatic eth_rx_pkg::crc_t crc_byte(input eth_rx_pkg::crc_t crc,
                                                  input eth_rx_pkg::byte_t data);
        eth_rx_pkg::crc_t c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_nxt = crc_byte(crc_q, in.data);
    assign fcs_ok = (crc_nxt == CRC_MAGIC);

    // Oldest byte can leave once four are queued
    assign sr_full = (byte_cnt >= SR_DEPTH);

    // byte_cnt excludes the byte now on the input
    assign too_short = ((byte_cnt + 1'b1) < MIN_LEN);
    assign frame_bad = too_short | in.user;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            crc_q     <= CRC_INIT;
            byte_cnt  <= '0;
            out.valid <= 1'b0;
            out.last  <= 1'b0;
            out.user  <= 1'b0;
            bad_frame <= 1'b0;
            bad_fcs   <= 1'b0;
        end else begin
            out.valid <= in.valid & sr_full;
            out.last  <= in.valid & in.last & sr_full;
            out.user  <= in.valid & in.last & sr_full & (frame_bad | !fcs_ok);
            bad_frame <= in.valid & in.last & frame_bad;
            // FCS error only counts when the frame is otherwise fine
            bad_fcs   <= in.valid & in.last & !frame_bad & !fcs_ok;
            if (in.valid) begin
                if (in.last) begin
                    crc_q    <= CRC_INIT;
                    byte_cnt <= '0;
                end else begin
                    crc_q <= crc_nxt;
                    if (byte_cnt != MIN_LEN) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // Delay line that holds back the FCS
    always_ff @(posedge logic_clk) begin
        if (in.valid) begin
            delay_sr[0] <= in.data;
            delay_sr[1] <= delay_sr[0];
            delay_sr[2] <= delay_sr[1];
            delay_sr[3] <= delay_sr[2];
            out.data    <= delay_sr[3];
        end
    end

    // An FCS error is exclusive of a bad frame, and its frame leaves marked bad
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        bad_fcs |-> !bad_frame && out.valid && out.last && out.user);

endmodule

`default_nettype wire

// File: hdl/mii_rx_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_defs.svh"

module mii_rx_decode (
    input  wire                   logic_clk,
    input  wire                   logic_rst,
    input  eth_rx_pkg::nibble_t   mii_rxd,
    input  wire                   mii_rx_dv,
    input  wire                   mii_rx_er,
    eth_rx_stream_if.source       out
);

    eth_rx_pkg::decode_state_t state;
    eth_rx_pkg::nibble_t low_nib;
    eth_rx_pkg::byte_t hold_byte;
    eth_rx_pkg::byte_t rx_byte;
    logic nib_phase;
    logic hold_valid;
    logic err_seen;
    logic emit;

    // Low nibble arrives first on MII
    assign rx_byte = {mii_rxd, low_nib};

    // Held byte leaves when the next byte completes or when dv drops
    assign emit = (state == eth_rx_pkg::PAYLOAD) && hold_valid &&
                  (!mii_rx_dv || nib_phase);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state      <= eth_rx_pkg::IDLE;
            nib_phase  <= 1'b0;
            hold_valid <= 1'b0;
            err_seen   <= 1'b0;
            out.valid  <= 1'b0;
            out.last   <= 1'b0;
            out.user   <= 1'b0;
        end else begin
            out.valid <= emit;
            out.last  <= 1'b0;
            out.user  <= 1'b0;
            case (state)
                eth_rx_pkg::IDLE: begin
                    hold_valid <= 1'b0;
                    err_seen   <= 1'b0;
                    if (mii_rx_dv) begin
                        nib_phase <= 1'b1;
                        state     <= eth_rx_pkg::PREAMBLE;
                    end
                end
                eth_rx_pkg::PREAMBLE: begin
                    if (!mii_rx_dv) begin
                        nib_phase <= 1'b0;
                        state     <= eth_rx_pkg::IDLE;
                    end else begin
                        nib_phase <= ~nib_phase;
                        // Check each whole byte against SFD and preamble
                        if (nib_phase) begin
                            if (rx_byte == `ETH_SFD_BYTE) begin
                                state <= eth_rx_pkg::PAYLOAD;
                            end else if (rx_byte != `ETH_PREAMBLE_BYTE) begin
                                state <= eth_rx_pkg::DROP;
                            end
                        end
                    end
                end
                eth_rx_pkg::PAYLOAD: begin
                    if (mii_rx_dv) begin
                        nib_phase <= ~nib_phase;
                        err_seen  <= err_seen | mii_rx_er;
                        if (nib_phase) begin
                            hold_valid <= 1'b1;
                        end
                    end else begin
                        // Flush the held byte as the end of the frame
                        out.last   <= hold_valid;
                        out.user   <= hold_valid & (err_seen | nib_phase);
                        hold_valid <= 1'b0;
                        nib_phase  <= 1'b0;
                        state      <= eth_rx_pkg::IDLE;
                    end
                end
                default: begin
                    nib_phase <= 1'b0;
                    if (!mii_rx_dv) begin
                        state <= eth_rx_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    // Nibble pairing and output byte
    always_ff @(posedge logic_clk) begin
        if (mii_rx_dv && !nib_phase) begin
            low_nib <= mii_rxd;
        end
        if (mii_rx_dv && nib_phase && state == eth_rx_pkg::PAYLOAD) begin
            hold_byte <= rx_byte;
        end
        if (emit) begin
            out.data <= hold_byte;
        end
    end

    // Outside the payload only the flushed final byte of a frame can leave
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (out.valid && (state != eth_rx_pkg::PAYLOAD)) |->
        (out.last && $past(state == eth_rx_pkg::PAYLOAD)));

endmodule

`default_nettype wire

// File: hdl/eth_rx_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// Byte stream between receive stages, no back-pressure
interface eth_rx_stream_if;

    eth_rx_pkg::byte_t data;
    logic valid;
    logic last;
    // Sampled with last, flags a bad frame
    logic user;

    modport source (
        output data,
        output valid,
        output last,
        output user
    );

    modport sink (
        input data,
        input valid,
        input last,
        input user
    );

endinterface

`default_nettype wire

// File: hdl/eth_rx_pkg.sv
`default_nettype none

`include "eth_rx_defs.svh"

package eth_rx_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [3:0] nibble_t;
    typedef logic [31:0] crc_t;

    // Extra top bit tells a full FIFO from an empty one
    typedef logic [`ETH_RX_FIFO_ADDR_WIDTH:0] fifo_ptr_t;

    // Receive decoder states
    typedef enum logic [1:0] {
        IDLE,
        PREAMBLE,
        PAYLOAD,
        DROP
    } decode_state_t;

endpackage

`default_nettype wire

// File: hdl/eth_rx_defs.svh
`ifndef ETH_RX_DEFS_SVH
`define ETH_RX_DEFS_SVH

// Frame FIFO address bits, 64 entries
`define ETH_RX_FIFO_ADDR_WIDTH 6

// Minimum frame length counted with the FCS
`define ETH_RX_MIN_FRAME_LEN 64

// Preamble and start-of-frame delimiter as they appear on the wire
`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD_BYTE 8'hD5

`endif
